//--- rtl/mac_axis_pkg.sv
package mac_axis_pkg;

	// ********************
	// Word geometry
	// ********************

	// One MAC / AXI-Stream data word
	localparam int DATA_W = 32;
	// Byte lanes per word
	localparam int KEEP_W = DATA_W / 8;

	typedef logic [DATA_W-1:0] mac_word_t;

	// Bit 3 is the first byte on the wire (big endian)
	typedef logic [KEEP_W-1:0] axis_keep_t;

	// ********************
	// Encodings
	// ********************

	// MAC byte-enable code, counts valid bytes from the top lane
	typedef enum logic [1:0] {
		BE_FULL  = 2'b00,
		BE_THREE = 2'b11,
		BE_TWO   = 2'b10,
		BE_ONE   = 2'b01
	} mac_be_e;

	// Receive read FSM
	typedef enum logic [1:0] {
		RD_IDLE  = 2'b00,
		RD_BURST = 2'b01,
		RD_GAP   = 2'b10
	} rx_rd_state_e;

	// ********************
	// Parameter defaults
	// ********************

	// Transmit FIFO word: start, end, code, data
	localparam int DEF_TX_WORD_W = 1 + 1 + 2 + DATA_W;
	// Receive FIFO word: end, code, data
	localparam int DEF_RX_WORD_W = 1 + 2 + DATA_W;
	localparam int DEF_FIFO_DEPTH = 16;
	// Read requests stop at this fill level
	localparam int DEF_RX_THROTTLE = 10;

endpackage

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = 36,
	parameter int DEPTH = 16
) (
	input  logic                         Clk_user,
	input  logic                         Reset,
	// Write side
	input  logic [WIDTH-1:0]             din,
	input  logic                         wr_en,
	output logic                         full,
	// Read side, head word always on dout
	output logic [WIDTH-1:0]             dout,
	input  logic                         rd_en,
	output logic                         empty,
	// Occupancy
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	// Pointer and counter widths
	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	// ********************
	// Storage and pointers
	// ********************

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;

	// Qualified strobes, overflow and underflow ignored
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign full  = (count == CW'(DEPTH));
	assign empty = (count == '0);

	// First word falls through
	assign dout = mem[rd_ptr];

	// Payload array
	always_ff @(posedge Clk_user) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	// Pointers wrap at DEPTH, not only at a power of two
	always_ff @(posedge Clk_user or posedge Reset) begin
		if (Reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy counter
	always_ff @(posedge Clk_user or posedge Reset) begin
		if (Reset) begin
			count <= '0;
		end else begin
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				// Both or neither, level unchanged
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/axis_tx_packer.sv
`timescale 1ns/10ps

module axis_tx_packer #(
	parameter int TX_WORD_W  = mac_axis_pkg::DEF_TX_WORD_W,
	parameter int FIFO_DEPTH = mac_axis_pkg::DEF_FIFO_DEPTH
) (
	input  logic                    Clk_user,
	input  logic                    Reset,
	// AXI-Stream slave
	input  mac_axis_pkg::mac_word_t  tx_mac_tdata,
	input  mac_axis_pkg::axis_keep_t tx_mac_tkeep,
	input  logic                    tx_mac_tlast,
	input  logic                    tx_mac_tvalid,
	output logic                    tx_mac_tready,
	// MAC transmit user interface
	input  logic                    mac_tx_wa,
	output logic                    mac_tx_wr,
	output mac_axis_pkg::mac_word_t  mac_tx_data,
	output mac_axis_pkg::mac_be_e    mac_tx_be,
	output logic                    mac_tx_sop,
	output logic                    mac_tx_eop
);

	import mac_axis_pkg::*;

	logic                 beat;
	logic                 in_pkt;
	mac_be_e              tx_be;
	logic                 fifo_full;
	logic                 fifo_empty;
	logic [TX_WORD_W-1:0] fifo_din;
	logic [TX_WORD_W-1:0] fifo_dout;

	// ********************
	// AXI side
	// ********************

	assign tx_mac_tready = !fifo_full;
	assign beat = tx_mac_tvalid && tx_mac_tready;

	// Inside a packet after a non-last beat
	// Last beat clears it, so single-beat packets leave it low
	always_ff @(posedge Clk_user or posedge Reset) begin
		if (Reset) begin
			in_pkt <= 1'b0;
		end else if (beat) begin
			in_pkt <= !tx_mac_tlast;
		end
	end

	// Keep to byte-enable code, highest matching pattern wins
	always_comb begin
		casez (tx_mac_tkeep)
			4'b1110: tx_be = BE_THREE;
			4'b110?: tx_be = BE_TWO;
			4'b10??: tx_be = BE_ONE;
			default: tx_be = BE_FULL;
		endcase
	end

	// Start flag on the top bit
	assign fifo_din = {!in_pkt, tx_mac_tlast, tx_be, tx_mac_tdata};

	sync_fifo #(
		.WIDTH (TX_WORD_W),
		.DEPTH (FIFO_DEPTH)
	) u_tx_fifo (
		.Clk_user (Clk_user),
		.Reset    (Reset),
		.din      (fifo_din),
		.wr_en    (beat),
		.full     (fifo_full),
		.dout     (fifo_dout),
		.rd_en    (mac_tx_wr),
		.empty    (fifo_empty),
		.count    ()
	);

	// ********************
	// MAC side
	// ********************

	// Drain while MAC signals room
	assign mac_tx_wr   = !fifo_empty && mac_tx_wa;
	assign mac_tx_sop  = fifo_dout[TX_WORD_W-1];
	assign mac_tx_eop  = fifo_dout[TX_WORD_W-2];
	assign mac_tx_be   = mac_be_e'(fifo_dout[DATA_W+1:DATA_W]);
	assign mac_tx_data = fifo_dout[DATA_W-1:0];

endmodule

//--- rtl/mac_rx_reader.sv
`timescale 1ns/10ps

module mac_rx_reader #(
	parameter int FIFO_DEPTH  = mac_axis_pkg::DEF_FIFO_DEPTH,
	parameter int RX_THROTTLE = mac_axis_pkg::DEF_RX_THROTTLE
) (
	input  logic                             Clk_user,
	input  logic                             Reset,
	// MAC receive status
	input  logic                             mac_rx_ra,
	input  logic                             mac_rx_pa,
	input  logic                             mac_rx_eop,
	// Receive FIFO fill level
	input  logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_count,
	// Read request to the MAC
	output logic                             mac_rx_rd
);

	import mac_axis_pkg::*;

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	rx_rd_state_e state;
	logic         room;

	// Free slots above the throttle cover words already in flight
	assign room = (fifo_count < CW'(RX_THROTTLE));

	// ********************
	// Read FSM
	// ********************

	always_ff @(posedge Clk_user or posedge Reset) begin
		if (Reset) begin
			state     <= RD_IDLE;
			mac_rx_rd <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					// Packet waiting, first request next cycle
					if (mac_rx_ra) begin
						state     <= RD_BURST;
						mac_rx_rd <= room;
					end
				end
				RD_BURST: begin
					// Stop at the packet's last word
					if (mac_rx_pa && mac_rx_eop) begin
						state     <= RD_GAP;
						mac_rx_rd <= 1'b0;
					end else begin
						mac_rx_rd <= room;
					end
				end
				RD_GAP: begin
					// One idle cycle so ra can drop
					state <= RD_IDLE;
				end
				default: begin
					state     <= RD_IDLE;
					mac_rx_rd <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- rtl/axis_rx_unpacker.sv
`timescale 1ns/10ps

module axis_rx_unpacker #(
	parameter int RX_WORD_W  = mac_axis_pkg::DEF_RX_WORD_W,
	parameter int FIFO_DEPTH = mac_axis_pkg::DEF_FIFO_DEPTH
) (
	input  logic                             Clk_user,
	input  logic                             Reset,
	// MAC receive data
	input  logic                             mac_rx_pa,
	input  mac_axis_pkg::mac_word_t           mac_rx_data,
	input  mac_axis_pkg::mac_be_e             mac_rx_be,
	input  logic                             mac_rx_eop,
	// Fill level for the read FSM
	output logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_count,
	// AXI-Stream master
	output mac_axis_pkg::mac_word_t           rx_mac_tdata,
	output mac_axis_pkg::axis_keep_t          rx_mac_tkeep,
	output logic                             rx_mac_tlast,
	output logic                             rx_mac_tvalid,
	input  logic                             rx_mac_tready
);

	import mac_axis_pkg::*;

	logic [RX_WORD_W-1:0] fifo_din;
	logic [RX_WORD_W-1:0] fifo_dout;
	logic                 fifo_empty;
	mac_be_e              head_be;

	// End flag on top, no start bit needed
	assign fifo_din = {mac_rx_eop, mac_rx_be, mac_rx_data};

	// Every pa word goes in, reader throttle prevents overflow
	sync_fifo #(
		.WIDTH (RX_WORD_W),
		.DEPTH (FIFO_DEPTH)
	) u_rx_fifo (
		.Clk_user (Clk_user),
		.Reset    (Reset),
		.din      (fifo_din),
		.wr_en    (mac_rx_pa),
		.full     (),
		.dout     (fifo_dout),
		.rd_en    (rx_mac_tvalid && rx_mac_tready),
		.empty    (fifo_empty),
		.count    (fifo_count)
	);

	// ********************
	// AXI presentation
	// ********************

	// Head word held until accepted
	assign rx_mac_tvalid = !fifo_empty;
	assign rx_mac_tlast  = fifo_dout[RX_WORD_W-1];
	assign head_be       = mac_be_e'(fifo_dout[DATA_W+1:DATA_W]);
	assign rx_mac_tdata  = fifo_dout[DATA_W-1:0];

	// Code to keep, valid bytes from the top lane down
	always_comb begin
		rx_mac_tkeep = 4'b1111;
		case (head_be)
			BE_THREE: rx_mac_tkeep = 4'b1110;
			BE_TWO:   rx_mac_tkeep = 4'b1100;
			BE_ONE:   rx_mac_tkeep = 4'b1000;
			default:  rx_mac_tkeep = 4'b1111;
		endcase
	end

endmodule

//--- rtl/mac_axis_bridge.sv
`timescale 1ns/10ps

module mac_axis_bridge #(
	parameter int TX_WORD_W   = mac_axis_pkg::DEF_TX_WORD_W,
	parameter int RX_WORD_W   = mac_axis_pkg::DEF_RX_WORD_W,
	parameter int FIFO_DEPTH  = mac_axis_pkg::DEF_FIFO_DEPTH,
	parameter int RX_THROTTLE = mac_axis_pkg::DEF_RX_THROTTLE
) (
	input  logic                     Clk_user,
	input  logic                     Reset,

	// Transmit AXI-Stream slave
	input  mac_axis_pkg::mac_word_t   tx_mac_tdata,
	input  mac_axis_pkg::axis_keep_t  tx_mac_tkeep,
	input  logic                     tx_mac_tlast,
	input  logic                     tx_mac_tvalid,
	output logic                     tx_mac_tready,

	// Receive AXI-Stream master
	output mac_axis_pkg::mac_word_t   rx_mac_tdata,
	output mac_axis_pkg::axis_keep_t  rx_mac_tkeep,
	output logic                     rx_mac_tlast,
	output logic                     rx_mac_tvalid,
	input  logic                     rx_mac_tready,

	// MAC transmit user interface
	input  logic                     mac_tx_wa,
	output logic                     mac_tx_wr,
	output mac_axis_pkg::mac_word_t   mac_tx_data,
	output mac_axis_pkg::mac_be_e     mac_tx_be,
	output logic                     mac_tx_sop,
	output logic                     mac_tx_eop,

	// MAC receive user interface
	input  logic                     mac_rx_ra,
	output logic                     mac_rx_rd,
	input  logic                     mac_rx_pa,
	input  mac_axis_pkg::mac_word_t   mac_rx_data,
	input  mac_axis_pkg::mac_be_e     mac_rx_be,
	// Start marker kept for interface completeness, not used
	input  logic                     mac_rx_sop,
	input  logic                     mac_rx_eop
);

	// Receive FIFO level back to the read FSM
	logic [$clog2(FIFO_DEPTH+1)-1:0] rx_fifo_count;

	// ********************
	// Transmit path
	// ********************

	axis_tx_packer #(
		.TX_WORD_W  (TX_WORD_W),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_tx_packer (
		.Clk_user      (Clk_user),
		.Reset         (Reset),
		.tx_mac_tdata  (tx_mac_tdata),
		.tx_mac_tkeep  (tx_mac_tkeep),
		.tx_mac_tlast  (tx_mac_tlast),
		.tx_mac_tvalid (tx_mac_tvalid),
		.tx_mac_tready (tx_mac_tready),
		.mac_tx_wa     (mac_tx_wa),
		.mac_tx_wr     (mac_tx_wr),
		.mac_tx_data   (mac_tx_data),
		.mac_tx_be     (mac_tx_be),
		.mac_tx_sop    (mac_tx_sop),
		.mac_tx_eop    (mac_tx_eop)
	);

	// ********************
	// Receive path
	// ********************

	// Request side, throttled on FIFO fill
	mac_rx_reader #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.RX_THROTTLE (RX_THROTTLE)
	) u_rx_reader (
		.Clk_user   (Clk_user),
		.Reset      (Reset),
		.mac_rx_ra  (mac_rx_ra),
		.mac_rx_pa  (mac_rx_pa),
		.mac_rx_eop (mac_rx_eop),
		.fifo_count (rx_fifo_count),
		.mac_rx_rd  (mac_rx_rd)
	);

	// Buffering and AXI presentation
	axis_rx_unpacker #(
		.RX_WORD_W  (RX_WORD_W),
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_rx_unpacker (
		.Clk_user      (Clk_user),
		.Reset         (Reset),
		.mac_rx_pa     (mac_rx_pa),
		.mac_rx_data   (mac_rx_data),
		.mac_rx_be     (mac_rx_be),
		.mac_rx_eop    (mac_rx_eop),
		.fifo_count    (rx_fifo_count),
		.rx_mac_tdata  (rx_mac_tdata),
		.rx_mac_tkeep  (rx_mac_tkeep),
		.rx_mac_tlast  (rx_mac_tlast),
		.rx_mac_tvalid (rx_mac_tvalid),
		.rx_mac_tready (rx_mac_tready)
	);

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
	parameter real PERIOD = 8.0
) (
	output logic Clk_user
);

	// Free-running clock, starts low
	initial begin
		Clk_user = 1'b0;
		forever begin
			#(PERIOD / 2.0) Clk_user = ~Clk_user;
		end
	end

endmodule

//--- verif/mac_axis_bridge_props.sv
`timescale 1ns/10ps

module mac_axis_bridge_props (
	input logic                    Clk_user,
	input logic                    Reset,
	input logic                    mac_tx_wr,
	input logic                    mac_tx_wa,
	input logic                    rx_mac_tvalid,
	input logic                    rx_mac_tready,
	input mac_axis_pkg::mac_word_t rx_mac_tdata,
	input logic                    rx_mac_tlast,
	input logic                    mac_rx_rd,
	input logic                    mac_rx_pa,
	input logic                    mac_rx_eop
);

	// Number of failed assertions so far
	int error_count = 0;

	// ********************
	// Transmit side
	// ********************

	// MAC write only while it has room
	a_wr_needs_room: assert property (
		@(posedge Clk_user) disable iff (Reset) mac_tx_wr |-> mac_tx_wa
	) else begin
		$error("mac_tx_wr high while mac_tx_wa low");
		error_count++;
	end

	// ********************
	// Receive side
	// ********************

	// Stalled beat keeps its word
	a_rx_hold: assert property (
		@(posedge Clk_user) disable iff (Reset)
		rx_mac_tvalid && !rx_mac_tready |=>
			rx_mac_tvalid && $stable(rx_mac_tdata) && $stable(rx_mac_tlast)
	) else begin
		$error("rx beat changed while tready low");
		error_count++;
	end

	// No read request right after the last word
	a_rd_stops: assert property (
		@(posedge Clk_user) disable iff (Reset) mac_rx_pa && mac_rx_eop |=> !mac_rx_rd
	) else begin
		$error("mac_rx_rd high the cycle after eop");
		error_count++;
	end

endmodule

bind mac_axis_bridge mac_axis_bridge_props u_props (.*);

//--- verif/tb_mac_axis_bridge.sv
`timescale 1ns/10ps

module tb_mac_axis_bridge;

	import mac_axis_pkg::*;

	localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
	localparam int WAIT_LIMIT = 20000;

	logic       Clk_user;
	logic       Reset;
	mac_word_t  tx_mac_tdata;
	axis_keep_t tx_mac_tkeep;
	logic       tx_mac_tlast;
	logic       tx_mac_tvalid;
	logic       tx_mac_tready;
	mac_word_t  rx_mac_tdata;
	axis_keep_t rx_mac_tkeep;
	logic       rx_mac_tlast;
	logic       rx_mac_tvalid;
	logic       rx_mac_tready;
	logic       mac_tx_wa;
	logic       mac_tx_wr;
	mac_word_t  mac_tx_data;
	mac_be_e    mac_tx_be;
	logic       mac_tx_sop;
	logic       mac_tx_eop;
	logic       mac_rx_ra;
	logic       mac_rx_rd;
	logic       mac_rx_pa;
	mac_word_t  mac_rx_data;
	mac_be_e    mac_rx_be;
	logic       mac_rx_sop;
	logic       mac_rx_eop;

	integer seed;
	// Traffic shaping knobs
	logic   wa_hold;
	logic   rx_stall;
	int     ready_left;
	int     tx_beats;
	// MAC receive model state
	logic   rd_seen;
	logic   pkt_open;
	int     rx_gap;

	// Expected words on the MAC transmit side
	mac_word_t  exp_tx_data[$];
	mac_be_e    exp_tx_be[$];
	logic       exp_tx_sop[$];
	logic       exp_tx_eop[$];
	// Expected beats on the AXI receive side
	mac_word_t  exp_rx_data[$];
	axis_keep_t exp_rx_keep[$];
	logic       exp_rx_last[$];
	// Words the MAC receive model still has to supply
	mac_word_t  src_data[$];
	mac_be_e    src_be[$];
	logic       src_sop[$];
	logic       src_eop[$];

	tb_clk_gen #(.PERIOD(8.0)) u_clk (.Clk_user(Clk_user));

	mac_axis_bridge #(
		.TX_WORD_W   (DEF_TX_WORD_W),
		.RX_WORD_W   (DEF_RX_WORD_W),
		.FIFO_DEPTH  (FIFO_DEPTH),
		.RX_THROTTLE (DEF_RX_THROTTLE)
	) UUT (.*);

	// ********************
	// Reference and helpers
	// ********************

	function automatic int rand_range(int n);
		return {$random(seed)} % n;
	endfunction

	// Valid lanes counted from the first byte on the wire
	function automatic mac_be_e keep_to_code(axis_keep_t keep);
		int lanes;
		lanes = 0;
		for (int i = KEEP_W - 1; i >= 0; i--) begin
			if (!keep[i])
				break;
			lanes++;
		end
		case (lanes)
			3: return BE_THREE;
			2: return BE_TWO;
			1: return BE_ONE;
			default: return BE_FULL;
		endcase
	endfunction

	// Code back to a mask of top lanes
	function automatic axis_keep_t code_to_keep(mac_be_e code);
		int lanes;
		case (code)
			BE_THREE: lanes = 3;
			BE_TWO:   lanes = 2;
			BE_ONE:   lanes = 1;
			default:  lanes = 4;
		endcase
		return ~(4'b1111 >> lanes);
	endfunction

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic fail_value(string msg);
		fail_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
	endtask

	task automatic check_level(string what, logic got, logic exp);
		if (got !== exp)
			fail_value($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_count(string what, int got, int exp);
		if (got != exp)
			fail_value($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_tx_word(mac_word_t data, mac_be_e be, logic sop, logic eop);
		mac_word_t exp_data;
		mac_be_e   exp_be;
		logic      exp_sop;
		logic      exp_eop;
		if (exp_tx_data.size() == 0) begin
			fail_run("The MAC transmit side wrote a word that was never sent");
		end else begin
			exp_data = exp_tx_data.pop_front();
			exp_be   = exp_tx_be.pop_front();
			exp_sop  = exp_tx_sop.pop_front();
			exp_eop  = exp_tx_eop.pop_front();
			if (data !== exp_data || be !== exp_be || sop !== exp_sop || eop !== exp_eop)
				fail_value($sformatf("tx %h %s sop %b eop %b, expected %h %s sop %b eop %b",
					data, be.name(), sop, eop, exp_data, exp_be.name(), exp_sop, exp_eop));
		end
	endtask

	task automatic check_rx_word(mac_word_t data, axis_keep_t keep, logic last);
		mac_word_t  exp_data;
		axis_keep_t exp_keep;
		logic       exp_last;
		if (exp_rx_data.size() == 0) begin
			fail_run("The AXI receive side sent a beat the MAC never supplied");
		end else begin
			exp_data = exp_rx_data.pop_front();
			exp_keep = exp_rx_keep.pop_front();
			exp_last = exp_rx_last.pop_front();
			if (data !== exp_data || keep !== exp_keep || last !== exp_last)
				fail_value($sformatf("rx %h keep %b last %b, expected %h keep %b last %b",
					data, keep, last, exp_data, exp_keep, exp_last));
		end
	endtask

	// ********************
	// Stimulus tasks
	// ********************

	// One packet on the AXI transmit side, tvalid left high after the last beat
	task automatic send_tx_packet(int len);
		axis_keep_t last_keep;
		logic       taken;
		int         cyc;
		case (rand_range(4))
			0: last_keep = 4'b1110;
			1: last_keep = 4'b1100;
			2: last_keep = 4'b1000;
			default: last_keep = 4'b1111;
		endcase
		for (int i = 0; i < len; i++) begin
			@(negedge Clk_user);
			tx_mac_tdata  = $random(seed);
			tx_mac_tkeep  = (i == len - 1) ? last_keep : 4'b1111;
			tx_mac_tlast  = (i == len - 1);
			tx_mac_tvalid = 1'b1;
			exp_tx_data.push_back(tx_mac_tdata);
			exp_tx_be.push_back(keep_to_code(tx_mac_tkeep));
			exp_tx_sop.push_back(i == 0);
			exp_tx_eop.push_back(i == len - 1);
			cyc = 0;
			do begin
				@(posedge Clk_user);
				taken = tx_mac_tready;
				cyc++;
			end while (!taken && cyc < WAIT_LIMIT);
			if (!taken)
				fail_run("Timeout: a transmit beat was never accepted");
			tx_beats++;
		end
	endtask

	task automatic tx_idle(int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge Clk_user);
			tx_mac_tvalid = 1'b0;
			tx_mac_tlast  = 1'b0;
		end
	endtask

	// Words handed to the MAC receive model
	task automatic queue_rx_packet(int len);
		for (int i = 0; i < len; i++) begin
			src_data.push_back($random(seed));
			src_be.push_back((i == len - 1) ? mac_be_e'(rand_range(4)) : BE_FULL);
			src_sop.push_back(i == 0);
			src_eop.push_back(i == len - 1);
		end
	endtask

	function automatic logic drained();
		return exp_tx_data.size() == 0 && exp_rx_data.size() == 0 &&
			src_data.size() == 0 && !pkt_open;
	endfunction

	task automatic wait_drained(string what);
		int cyc;
		cyc = 0;
		while (!drained() && cyc < WAIT_LIMIT) begin
			@(posedge Clk_user);
			cyc++;
		end
		if (!drained())
			fail_run({"Timeout: traffic did not drain during ", what});
	endtask

	task automatic wait_tready_low();
		int cyc;
		logic ready;
		cyc = 0;
		do begin
			@(posedge Clk_user);
			ready = tx_mac_tready;
			cyc++;
		end while (ready && cyc < WAIT_LIMIT);
		if (ready)
			fail_run("Timeout: tx_mac_tready never fell with the MAC out of room");
	endtask

	// ********************
	// MAC and sink models
	// ********************

	// Room level, high through reset so wr low shows an empty FIFO
	// Forced low for the back-pressure test
	always @(negedge Clk_user) begin
		if (Reset !== 1'b0)
			mac_tx_wa = 1'b1;
		else if (wa_hold)
			mac_tx_wa = 1'b0;
		else
			mac_tx_wa = (rand_range(4) != 0);
	end

	// Ready in random stretches, long low ones when stalling
	always @(negedge Clk_user) begin
		if (Reset !== 1'b0) begin
			rx_mac_tready = 1'b0;
		end else if (ready_left > 0) begin
			ready_left--;
		end else begin
			rx_mac_tready = !rx_mac_tready;
			if (rx_mac_tready)
				ready_left = rand_range(4);
			else
				ready_left = rx_stall ? 8 + rand_range(32) : rand_range(3);
		end
	end

	// MAC receive: one pa word a cycle after each rd
	always begin
		@(posedge Clk_user);
		rd_seen = mac_rx_rd;
		@(negedge Clk_user);
		mac_rx_pa  = 1'b0;
		mac_rx_sop = 1'b0;
		mac_rx_eop = 1'b0;
		if (Reset) begin
			mac_rx_ra = 1'b0;
		end else if (rd_seen && pkt_open) begin
			mac_rx_pa   = 1'b1;
			mac_rx_data = src_data.pop_front();
			mac_rx_be   = src_be.pop_front();
			mac_rx_sop  = src_sop.pop_front();
			mac_rx_eop  = src_eop.pop_front();
			exp_rx_data.push_back(mac_rx_data);
			exp_rx_keep.push_back(code_to_keep(mac_rx_be));
			exp_rx_last.push_back(mac_rx_eop);
			// Packet done, ra low for a short gap
			if (mac_rx_eop) begin
				pkt_open  = 1'b0;
				mac_rx_ra = 1'b0;
				rx_gap    = 1 + rand_range(3);
			end
		end else if (!pkt_open) begin
			if (rx_gap > 0) begin
				rx_gap--;
			end else if (src_data.size() != 0) begin
				pkt_open  = 1'b1;
				mac_rx_ra = 1'b1;
			end
		end
	end

	// Comparing process, samples on the rising edge
	always @(posedge Clk_user) begin
		if (!Reset) begin
			if (UUT.u_props.error_count != 0)
				fail_run("A protocol assertion on the bridge failed");
			if (mac_tx_wr)
				check_tx_word(mac_tx_data, mac_tx_be, mac_tx_sop, mac_tx_eop);
			if (rx_mac_tvalid && rx_mac_tready)
				check_rx_word(rx_mac_tdata, rx_mac_tkeep, rx_mac_tlast);
		end
	end

	// ********************
	// Test sequence
	// ********************

	initial begin
		seed          = 32'h22b0_ece6;
		Reset         = 1'b1;
		tx_mac_tdata  = '0;
		tx_mac_tkeep  = '0;
		tx_mac_tlast  = 1'b0;
		tx_mac_tvalid = 1'b0;
		rx_mac_tready = 1'b0;
		mac_tx_wa     = 1'b1;
		mac_rx_ra     = 1'b0;
		mac_rx_pa     = 1'b0;
		mac_rx_data   = '0;
		mac_rx_be     = BE_FULL;
		mac_rx_sop    = 1'b0;
		mac_rx_eop    = 1'b0;
		wa_hold       = 1'b0;
		rx_stall      = 1'b0;
		ready_left    = 0;
		tx_beats      = 0;
		pkt_open      = 1'b0;
		rx_gap        = 0;
		repeat (2) @(posedge Clk_user);
		@(negedge Clk_user);
		// Levels while in reset
		check_level("tx_mac_tready", tx_mac_tready, 1'b1);
		check_level("mac_tx_wr", mac_tx_wr, 1'b0);
		check_level("mac_rx_rd", mac_rx_rd, 1'b0);
		check_level("rx_mac_tvalid", rx_mac_tvalid, 1'b0);
		Reset = 1'b0;

		// Single-beat packets lead on both paths
		queue_rx_packet(1);
		queue_rx_packet(1);
		queue_rx_packet(3);
		for (int i = 0; i < 30; i++)
			queue_rx_packet(1 + rand_range(8));
		send_tx_packet(1);
		send_tx_packet(1);
		send_tx_packet(2);
		for (int i = 0; i < 30; i++) begin
			send_tx_packet(1 + rand_range(8));
			tx_idle(rand_range(3));
		end
		tx_idle(1);
		wait_drained("mixed traffic");

		// MAC out of room until the FIFO fills
		wa_hold = 1'b1;
		repeat (2) @(negedge Clk_user);
		tx_beats = 0;
		fork
			begin
				repeat (3) send_tx_packet(8);
				tx_idle(1);
			end
			begin
				wait_tready_low();
				check_count("beats accepted before tready fell", tx_beats, FIFO_DEPTH);
				wa_hold = 1'b0;
			end
		join
		wait_drained("transmit back-pressure");

		// Long receive stalls against the read throttle
		rx_stall = 1'b1;
		for (int i = 0; i < 20; i++)
			queue_rx_packet(1 + rand_range(8));
		wait_drained("receive back-pressure");
		rx_stall = 1'b0;

		if (drained() && UUT.u_props.error_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			fail_run("Words were left unchecked at the end of the run");
		end
	end

endmodule

//--- all.f
rtl/mac_axis_pkg.sv
rtl/sync_fifo.sv
rtl/axis_tx_packer.sv
rtl/mac_rx_reader.sv
rtl/axis_rx_unpacker.sv
rtl/mac_axis_bridge.sv
verif/tb_clk_gen.sv
verif/mac_axis_bridge_props.sv
verif/tb_mac_axis_bridge.sv
